// ==== sd_card_macros.svh ====
/*
 * SD card emulation constants
 * NCR gap, sector geometry and data token values shared by the RTL
 */
`ifndef SD_CARD_MACROS_SVH
`define SD_CARD_MACROS_SVH

// filler bytes between last command byte and R1
`define SD_NCR 2

// one sector, one buffer
`define SD_SECTOR_BYTES 512
`define SD_BUF_AW 9

// data tokens on sdo
`define SD_TOKEN_START 8'hFE
`define SD_IDLE_BYTE 8'hFF

`endif

// ==== sd_proto_pkg.sv ====
/*
 * SD SPI protocol types
 * command codes, R1 values, received bytes, command frame and transmit job
 */
package sd_proto_pkg;

    // command byte as seen on the wire, start and tx bits included
    typedef enum logic [7:0] {
        CMD0   = 8'h40,
        CMD1   = 8'h41,
        CMD8   = 8'h48,
        CMD16  = 8'h50,
        CMD17  = 8'h51,
        ACMD41 = 8'h69,
        CMD55  = 8'h77,
        CMD58  = 8'h7A
    } sd_cmd_e;

    typedef enum logic [7:0] {
        R1_OK      = 8'h00,
        R1_IDLE    = 8'h01,
        R1_ILLEGAL = 8'h04,
        R1_PARAM   = 8'h40
    } sd_r1_e;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } sd_rx_byte_t;

    // CMD8 argument layout
    typedef struct packed {
        logic [19:0] rsvd;
        logic [3:0]  volt;
        logic [7:0]  check;
    } sd_if_cond_t;

    typedef union packed {
        logic [31:0] lba;
        sd_if_cond_t if_cond;
    } sd_arg_u;

    typedef struct packed {
        logic [7:0] cmd;
        sd_arg_u    arg;
    } sd_cmd_frame_t;

    // extra[3] goes out first
    typedef struct packed {
        logic            start;
        sd_r1_e          r1;
        logic [3:0][7:0] extra;
        logic [2:0]      extra_cnt;
        logic            is_read;
    } sd_tx_job_t;

endpackage

// ==== sd_host_pkg.sv ====
/*
 * host side types
 * sector read request and buffer write port of the I/O controller
 */
`include "sd_card_macros.svh"

package sd_host_pkg;

    // rd is a level, held until ack
    typedef struct packed {
        logic        rd;
        logic [31:0] lba;
    } host_req_t;

    typedef struct packed {
        logic                  we;
        logic [`SD_BUF_AW-1:0] addr;
        logic [7:0]            data;
    } host_buf_wr_t;

endpackage

// ==== sd_spi_rx.sv ====
/*
 * SPI receiver
 * samples sdi on rising sck, syncs on the first zero bit and
 * assembles MSB-first bytes, also flags falling sck for the transmitter
 */
`timescale 1ns/1ps

module sd_spi_rx (
    input  logic                      clk_sys,
    input  logic                      card_is_reset,
    input  logic                      sd_cs,
    input  logic                      sd_sck,
    input  logic                      sd_sdi,
    input  logic                      tx_done,
    output sd_proto_pkg::sd_rx_byte_t rx_byte,
    output logic                      sck_fall
);
    logic       sck_q;
    logic       sck_rise;
    logic       synced;
    logic [2:0] bit_cnt;
    logic [6:0] sbuf;

    // sck delayed by one clk_sys
    always_ff @(posedge clk_sys) begin
        sck_q <= sd_sck;
    end

    assign sck_rise = sd_sck & ~sck_q;
    assign sck_fall = sck_q & ~sd_sck;

    always_ff @(posedge clk_sys) begin
        rx_byte.valid <= 1'b0;
        if (card_is_reset || sd_cs || tx_done) begin
            // back to hunting for a start bit
            synced  <= 1'b0;
            bit_cnt <= 3'd0;
        end else if (sck_rise) begin
            if (!synced) begin
                // first zero is the MSB of the command byte
                if (!sd_sdi) begin
                    synced  <= 1'b1;
                    bit_cnt <= 3'd1;
                    sbuf    <= 7'd0;
                end
            end else begin
                sbuf    <= {sbuf[5:0], sd_sdi};
                bit_cnt <= bit_cnt + 3'd1;
                // eighth bit completes the byte
                if (bit_cnt == 3'd7) begin
                    rx_byte.valid <= 1'b1;
                    rx_byte.data  <= {sbuf, sd_sdi};
                end
            end
        end
    end

endmodule

// ==== sd_cmd_engine.sv ====
/*
 * SD command engine
 * frames six-byte commands, decodes them into a response job and runs
 * the sector read request/ack exchange with the host
 */
`timescale 1ns/1ps
`include "sd_card_macros.svh"

module sd_cmd_engine (
    input  logic                      clk_sys,
    input  logic                      card_is_reset,
    input  sd_proto_pkg::sd_rx_byte_t rx_byte,
    input  logic                      sdhc,
    input  logic                      tx_done,
    input  logic                      sd_ack,
    output sd_proto_pkg::sd_tx_job_t  tx_job,
    output logic                      data_ready,
    output sd_host_pkg::host_req_t    host_req
);
    import sd_proto_pkg::*;

    sd_cmd_frame_t frame;
    sd_tx_job_t    job_d;
    logic [2:0]    frame_cnt;
    logic          busy;
    logic          go_idle_seen;
    logic          cmd55;
    logic          issue;
    logic          ack_q;
    logic          rd_pending;
    logic [31:0]   ocr;

    // powered up, capacity bit, 2.7-3.6V window
    assign ocr = {1'b1, sdhc, 6'h00, 8'hFF, 8'h80, 8'h00};

    // crc byte closes the frame
    assign issue = rx_byte.valid && !busy && (frame_cnt == 3'd5);

    always_comb begin
        job_d       = '0;
        job_d.start = 1'b1;
        job_d.r1    = R1_ILLEGAL;
        if (frame.cmd == CMD0) begin
            job_d.r1 = R1_IDLE;
        end else if (go_idle_seen) begin
            // everything else only after CMD0
            case (frame.cmd)
                CMD1:  job_d.r1 = R1_OK;
                CMD8: begin
                    // R7 echoes voltage and check pattern
                    job_d.r1        = R1_IDLE;
                    job_d.extra     = {8'h00, 8'h00, {4'h0, frame.arg.if_cond.volt},
                                       frame.arg.if_cond.check};
                    job_d.extra_cnt = 3'd4;
                end
                CMD16: begin
                    if (frame.arg.lba == 32'(`SD_SECTOR_BYTES)) begin
                        job_d.r1 = R1_OK;
                    end else begin
                        job_d.r1 = R1_PARAM;
                    end
                end
                CMD17: begin
                    job_d.r1      = R1_OK;
                    job_d.is_read = 1'b1;
                end
                ACMD41: begin
                    if (cmd55) begin
                        job_d.r1 = R1_OK;
                    end
                end
                CMD55: job_d.r1 = R1_IDLE;
                CMD58: begin
                    job_d.r1        = R1_OK;
                    job_d.extra     = ocr;
                    job_d.extra_cnt = 3'd4;
                end
                default: job_d.r1 = R1_ILLEGAL;
            endcase
        end
    end

    // framing and job issue
    always_ff @(posedge clk_sys) begin
        tx_job.start <= 1'b0;
        if (card_is_reset) begin
            frame_cnt    <= 3'd0;
            busy         <= 1'b0;
            go_idle_seen <= 1'b0;
            cmd55        <= 1'b0;
        end else begin
            if (tx_done) begin
                busy <= 1'b0;
            end
            if (issue) begin
                tx_job    <= job_d;
                frame_cnt <= 3'd0;
                busy      <= 1'b1;
                cmd55     <= (frame.cmd == CMD55);
                if (frame.cmd == CMD0) begin
                    go_idle_seen <= 1'b1;
                end
            end else if (rx_byte.valid && !busy) begin
                if (frame_cnt == 3'd0) begin
                    // command byte is 01xxxxxx
                    if (rx_byte.data[7:6] == 2'b01) begin
                        frame.cmd <= rx_byte.data;
                        frame_cnt <= 3'd1;
                    end
                end else begin
                    // argument, MSB first
                    frame.arg.lba <= {frame.arg.lba[23:0], rx_byte.data};
                    frame_cnt     <= frame_cnt + 3'd1;
                end
            end
        end
    end

    // host request/ack exchange
    always_ff @(posedge clk_sys) begin
        if (card_is_reset) begin
            host_req.rd <= 1'b0;
            rd_pending  <= 1'b0;
            data_ready  <= 1'b0;
            ack_q       <= 1'b0;
        end else begin
            ack_q <= sd_ack;
            if (issue && job_d.is_read) begin
                host_req.rd  <= 1'b1;
                // byte address on SDSC cards
                host_req.lba <= sdhc ? frame.arg.lba : {9'd0, frame.arg.lba[31:9]};
                rd_pending   <= 1'b1;
            end else if (host_req.rd && sd_ack) begin
                host_req.rd <= 1'b0;
            end
            // falling ack means the sector is in the buffer
            if (rd_pending && ack_q && !sd_ack) begin
                data_ready <= 1'b1;
                rd_pending <= 1'b0;
            end
            if (tx_done) begin
                data_ready <= 1'b0;
                rd_pending <= 1'b0;
            end
        end
    end

endmodule

// ==== sd_spi_tx.sv ====
/*
 * SPI transmitter
 * byte slot sequencer for NCR fill, R1, extra bytes and the read
 * data block, shifting MSB first on falling sck
 */
`timescale 1ns/1ps
`include "sd_card_macros.svh"

module sd_spi_tx (
    input  logic                      clk_sys,
    input  logic                      card_is_reset,
    input  logic                      sd_cs,
    input  logic                      sck_fall,
    input  sd_proto_pkg::sd_rx_byte_t rx_byte,
    input  sd_proto_pkg::sd_tx_job_t  tx_job,
    input  logic                      data_ready,
    input  logic [7:0]                buf_rdata,
    output logic [`SD_BUF_AW-1:0]     buf_raddr,
    output logic                      sd_sdo,
    output logic                      tx_done
);
    import sd_proto_pkg::*;

    typedef enum logic [3:0] {
        PH_IDLE, PH_NCR, PH_R1, PH_EXTRA, PH_WAIT, PH_TOKEN, PH_DATA, PH_CRC, PH_DONE
    } tx_phase_e;

    tx_phase_e  phase;
    tx_phase_e  nxt_phase;
    sd_tx_job_t job;
    logic [9:0] cnt;
    logic [9:0] nxt_cnt;
    logic [7:0] nxt_byte;
    logic [7:0] sh;
    logic       slot_start;

    // data byte index doubles as buffer address
    assign buf_raddr = cnt[`SD_BUF_AW-1:0];

    // byte for the slot that starts now, and what follows it
    always_comb begin
        nxt_byte  = `SD_IDLE_BYTE;
        nxt_phase = phase;
        nxt_cnt   = cnt + 10'd1;
        case (phase)
            PH_NCR: begin
                if (cnt == 10'(`SD_NCR - 1)) begin
                    nxt_phase = PH_R1;
                end
            end
            PH_R1: begin
                nxt_byte = job.r1;
                nxt_cnt  = 10'd0;
                if (job.extra_cnt != 3'd0) begin
                    nxt_phase = PH_EXTRA;
                end else begin
                    nxt_phase = job.is_read ? PH_WAIT : PH_DONE;
                end
            end
            PH_EXTRA: begin
                nxt_byte = job.extra[2'd3 - cnt[1:0]];
                if (cnt[2:0] == job.extra_cnt - 3'd1) begin
                    nxt_phase = job.is_read ? PH_WAIT : PH_DONE;
                end
            end
            // 0xFF until the host has filled the buffer
            PH_WAIT: begin
                if (data_ready) begin
                    nxt_phase = PH_TOKEN;
                end
            end
            PH_TOKEN: begin
                nxt_byte  = `SD_TOKEN_START;
                nxt_cnt   = 10'd0;
                nxt_phase = PH_DATA;
            end
            PH_DATA: begin
                nxt_byte = buf_rdata;
                if (cnt == 10'(`SD_SECTOR_BYTES - 1)) begin
                    nxt_cnt   = 10'd0;
                    nxt_phase = PH_CRC;
                end
            end
            // dummy crc, two 0xFF bytes
            PH_CRC: begin
                if (cnt == 10'd1) begin
                    nxt_phase = PH_DONE;
                end
            end
            default: nxt_cnt = cnt;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        tx_done <= 1'b0;
        if (card_is_reset) begin
            phase      <= PH_IDLE;
            cnt        <= 10'd0;
            slot_start <= 1'b0;
            sh         <= 8'hFF;
            sd_sdo     <= 1'b1;
        end else if (sd_cs) begin
            // deselect aborts a running response
            phase      <= PH_IDLE;
            slot_start <= 1'b0;
            sd_sdo     <= 1'b1;
            tx_done    <= (phase != PH_IDLE);
        end else begin
            if (tx_job.start) begin
                job   <= tx_job;
                phase <= PH_NCR;
                cnt   <= 10'd0;
            end
            // byte tick ends a slot, next falling sck opens one
            if (rx_byte.valid) begin
                slot_start <= 1'b1;
                if (phase == PH_DONE) begin
                    phase   <= PH_IDLE;
                    tx_done <= 1'b1;
                end
            end
            if (sck_fall) begin
                if (slot_start) begin
                    slot_start <= 1'b0;
                    sd_sdo     <= nxt_byte[7];
                    sh         <= {nxt_byte[6:0], 1'b1};
                    phase      <= nxt_phase;
                    cnt        <= nxt_cnt;
                end else begin
                    sd_sdo <= sh[7];
                    sh     <= {sh[6:0], 1'b1};
                end
            end
        end
    end

endmodule

// ==== sd_sector_buffer.sv ====
/*
 * sector buffer
 * 512x8 RAM, host write port and registered transmitter read port
 */
`timescale 1ns/1ps
`include "sd_card_macros.svh"

module sd_sector_buffer (
    input  logic                      clk_sys,
    input  sd_host_pkg::host_buf_wr_t host_wr,
    input  logic [`SD_BUF_AW-1:0]     raddr,
    output logic [7:0]                rdata
);
    logic [7:0] mem [0:`SD_SECTOR_BYTES-1];

    // host fills the sector during ack
    always_ff @(posedge clk_sys) begin
        if (host_wr.we) begin
            mem[host_wr.addr] <= host_wr.data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk_sys) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== sd_card_top.sv ====
/*
 * emulated SD card, SPI mode
 * receiver, command engine, transmitter and sector buffer
 */
`timescale 1ns/1ps
`include "sd_card_macros.svh"

module sd_card_top (
    input  logic                      clk_sys,
    input  logic                      card_is_reset,
    input  logic                      sd_cs,
    input  logic                      sd_sck,
    input  logic                      sd_sdi,
    input  logic                      sdhc,
    input  logic                      sd_ack,
    input  sd_host_pkg::host_buf_wr_t host_wr,
    output logic                      sd_sdo,
    output sd_host_pkg::host_req_t    host_req
);
    import sd_proto_pkg::*;
    import sd_host_pkg::*;

    sd_rx_byte_t           rx_byte;
    sd_tx_job_t            tx_job;
    host_buf_wr_t          buf_wr;
    logic                  sck_fall;
    logic                  data_ready;
    logic                  tx_done;
    logic [`SD_BUF_AW-1:0] buf_raddr;
    logic [7:0]            buf_rdata;

    // writes only count while the host acks
    always_comb begin
        buf_wr    = host_wr;
        buf_wr.we = host_wr.we & sd_ack;
    end

    sd_spi_rx rx_i (
        .clk_sys       (clk_sys),
        .card_is_reset (card_is_reset),
        .sd_cs         (sd_cs),
        .sd_sck        (sd_sck),
        .sd_sdi        (sd_sdi),
        .tx_done       (tx_done),
        .rx_byte       (rx_byte),
        .sck_fall      (sck_fall)
    );

    sd_cmd_engine engine_i (
        .clk_sys       (clk_sys),
        .card_is_reset (card_is_reset),
        .rx_byte       (rx_byte),
        .sdhc          (sdhc),
        .tx_done       (tx_done),
        .sd_ack        (sd_ack),
        .tx_job        (tx_job),
        .data_ready    (data_ready),
        .host_req      (host_req)
    );

    sd_spi_tx tx_i (
        .clk_sys       (clk_sys),
        .card_is_reset (card_is_reset),
        .sd_cs         (sd_cs),
        .sck_fall      (sck_fall),
        .rx_byte       (rx_byte),
        .tx_job        (tx_job),
        .data_ready    (data_ready),
        .buf_rdata     (buf_rdata),
        .buf_raddr     (buf_raddr),
        .sd_sdo        (sd_sdo),
        .tx_done       (tx_done)
    );

    sd_sector_buffer buf_i (
        .clk_sys (clk_sys),
        .host_wr (buf_wr),
        .raddr   (buf_raddr),
        .rdata   (buf_rdata)
    );

endmodule

// ==== tb_sd_card.sv ====
/*
 * testbench for the SPI-mode SD card
 * SPI master, host sector model with LFSR data and a reference model
 * for R1, R7, OCR and the single-block read
 */
`timescale 1ns/1ps
`include "sd_card_macros.svh"

module tb_sd_card;
    import sd_host_pkg::*;

    // sck half period in clk_sys cycles
    localparam int SCK_HALF    = 4;
    localparam int R1_LIMIT    = 16;
    localparam int TOKEN_LIMIT = 2000;
    localparam int RD_LIMIT    = 4000;

    logic         clk_sys;
    logic         card_is_reset;
    logic         sd_cs;
    logic         sd_sck;
    logic         sd_sdi;
    logic         sdhc;
    logic         sd_ack;
    host_buf_wr_t host_wr;
    logic         sd_sdo;
    host_req_t    host_req;

    logic [31:0]  lfsr_state;
    logic [7:0]   sector_ref [0:`SD_SECTOR_BYTES-1];
    logic         ack_done;
    // reference model state
    logic         model_idle_seen;
    logic         model_cmd55;
    int           errors;
    int           test_errors;
    int           tests_run;
    int           tests_failed;

    sd_card_top dut_i (
        .clk_sys       (clk_sys),
        .card_is_reset (card_is_reset),
        .sd_cs         (sd_cs),
        .sd_sck        (sd_sck),
        .sd_sdi        (sd_sdi),
        .sdhc          (sdhc),
        .sd_ack        (sd_ack),
        .host_wr       (host_wr),
        .sd_sdo        (sd_sdo),
        .host_req      (host_req)
    );

    always #10 clk_sys = ~clk_sys;

    // fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          k;
        v = 32'h0;
        for (k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    // R1 as the card should answer, given the model state
    function automatic logic [7:0] expect_r1(input logic [5:0] idx, input logic [31:0] arg);
        logic [7:0] r;
        r = 8'h04;
        if (idx == 6'd0) begin
            r = 8'h01;
        end else if (model_idle_seen) begin
            case (idx)
                6'd1:    r = 8'h00;
                6'd8:    r = 8'h01;
                6'd16:   r = (arg == 32'd512) ? 8'h00 : 8'h40;
                6'd17:   r = 8'h00;
                6'd41:   r = model_cmd55 ? 8'h00 : 8'h04;
                6'd55:   r = 8'h01;
                6'd58:   r = 8'h00;
                default: r = 8'h04;
            endcase
        end
        return r;
    endfunction

    function automatic logic [31:0] expect_extra(input logic [5:0] idx, input logic [31:0] arg);
        logic [31:0] v;
        v = 32'h0;
        if (idx == 6'd8) begin
            // R7 echoes voltage field and check pattern
            v = {16'h0000, 4'h0, arg[11:8], arg[7:0]};
        end else if (idx == 6'd58) begin
            // OCR, capacity bit follows sdhc
            v = sdhc ? 32'hC0FF_8000 : 32'h80FF_8000;
        end
        return v;
    endfunction

    task automatic model_step(input logic [5:0] idx);
        if (idx == 6'd0) begin
            model_idle_seen = 1'b1;
        end
        model_cmd55 = (idx == 6'd55);
    endtask

    task automatic report_value(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
        errors++;
        $display("ERROR t=%0t %s: got %0h, expected %0h", $time, sig, got, exp);
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("t=%0t %s", $time, msg);
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    task automatic pulse_reset();
        card_is_reset = 1'b1;
        repeat (2) @(negedge clk_sys);
        card_is_reset = 1'b0;
        model_idle_seen = 1'b0;
        model_cmd55     = 1'b0;
        @(negedge clk_sys);
    endtask

    // mode 0 master, sdo sampled as sck rises
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        int i;
        for (i = 7; i >= 0; i--) begin
            sd_sdi = tx[i];
            repeat (SCK_HALF) @(negedge clk_sys);
            sd_sck = 1'b1;
            rx[i]  = sd_sdo;
            repeat (SCK_HALF) @(negedge clk_sys);
            sd_sck = 1'b0;
        end
    endtask

    // command byte, argument and a dummy crc
    task automatic send_cmd(input logic [5:0] idx, input logic [31:0] arg);
        logic [47:0] frame;
        logic [7:0]  dummy;
        int          k;
        frame = {2'b01, idx, arg, 8'h01};
        for (k = 0; k < 6; k++) begin
            spi_byte(frame[47:40], dummy);
            frame = {frame[39:0], 8'h00};
        end
    endtask

    // clock 0xFF until a non-idle byte, bounded
    task automatic wait_r1(output logic [7:0] r1, output int slot);
        r1   = 8'hFF;
        slot = 0;
        while (r1 == 8'hFF && slot < R1_LIMIT) begin
            spi_byte(8'hFF, r1);
            slot++;
        end
    endtask

    task automatic run_cmd(input logic [5:0] idx, input logic [31:0] arg);
        logic [7:0]  exp_r1;
        logic [7:0]  got;
        logic [7:0]  b;
        logic [31:0] exp_ext;
        logic [31:0] got_ext;
        logic        has_ext;
        int          slot;
        int          k;
        exp_r1  = expect_r1(idx, arg);
        exp_ext = expect_extra(idx, arg);
        has_ext = model_idle_seen && (idx == 6'd8 || idx == 6'd58);
        model_step(idx);
        send_cmd(idx, arg);
        wait_r1(got, slot);
        if (got == 8'hFF) begin
            report_fail($sformatf("no R1 for CMD%0d within %0d bytes", idx, R1_LIMIT));
        end else begin
            if (got != exp_r1) begin
                report_value($sformatf("r1 of CMD%0d", idx), 32'(got), 32'(exp_r1));
            end
            // R1 sits right after the NCR gap
            if (slot != `SD_NCR + 1) begin
                report_fail($sformatf("R1 of CMD%0d came in byte %0d, not after the NCR gap",
                                      idx, slot));
            end
            if (has_ext) begin
                got_ext = 32'h0;
                for (k = 0; k < 4; k++) begin
                    spi_byte(8'hFF, b);
                    got_ext = {got_ext[23:0], b};
                end
                if (got_ext != exp_ext) begin
                    report_value($sformatf("extra bytes of CMD%0d", idx), got_ext, exp_ext);
                end
            end
        end
    endtask

    // host side of a sector read, delay in clk_sys before ack
    task automatic host_serve(input logic [31:0] exp_lba, input int delay);
        logic [31:0] v;
        int          t;
        int          i;
        t = 0;
        while (!host_req.rd && t < RD_LIMIT) begin
            @(negedge clk_sys);
            t++;
        end
        if (!host_req.rd) begin
            report_fail("rd did not rise after CMD17");
        end else begin
            if (host_req.lba != exp_lba) begin
                report_value("host_req.lba", host_req.lba, exp_lba);
            end
            repeat (delay) @(negedge clk_sys);
            if (!host_req.rd) begin
                report_fail("rd fell before sd_ack rose");
            end
            sd_ack = 1'b1;
            @(negedge clk_sys);
            if (host_req.rd) begin
                report_fail("rd still high one clk_sys after sd_ack rose");
            end
            for (i = 0; i < `SD_SECTOR_BYTES; i++) begin
                v             = rand_bits(8);
                host_wr.we    = 1'b1;
                host_wr.addr  = i[`SD_BUF_AW-1:0];
                host_wr.data  = v[7:0];
                sector_ref[i] = v[7:0];
                @(negedge clk_sys);
            end
            host_wr.we = 1'b0;
            sd_ack     = 1'b0;
            ack_done   = 1'b1;
        end
    endtask

    // card side of a sector read, R1 then fill, token, data and crc
    task automatic read_block(input logic [31:0] arg);
        logic [7:0] exp_r1;
        logic [7:0] b;
        int         slot;
        int         n;
        int         i;
        exp_r1 = expect_r1(6'd17, arg);
        model_step(6'd17);
        send_cmd(6'd17, arg);
        wait_r1(b, slot);
        if (b == 8'hFF) begin
            report_fail("no R1 for CMD17 within 16 bytes");
        end else if (b != exp_r1) begin
            report_value("r1 of CMD17", 32'(b), 32'(exp_r1));
        end
        n = 0;
        b = 8'hFF;
        while (b == 8'hFF && n < TOKEN_LIMIT) begin
            spi_byte(8'hFF, b);
            n++;
        end
        if (b == 8'hFF) begin
            report_fail("no start token within 2000 bytes");
        end else if (b != `SD_TOKEN_START) begin
            report_value("start token", 32'(b), 32'(`SD_TOKEN_START));
        end else begin
            if (!ack_done) begin
                report_fail("start token came before sd_ack fell");
            end
            for (i = 0; i < `SD_SECTOR_BYTES; i++) begin
                spi_byte(8'hFF, b);
                if (b != sector_ref[i]) begin
                    report_value($sformatf("data[%0d]", i), 32'(b), 32'(sector_ref[i]));
                end
            end
            // filler crc
            for (i = 0; i < 2; i++) begin
                spi_byte(8'hFF, b);
                if (b != 8'hFF) begin
                    report_value($sformatf("crc[%0d]", i), 32'(b), 32'hFF);
                end
            end
        end
    endtask

    task automatic read_test(input logic mode, input logic long_wait);
        logic [31:0] arg;
        logic [31:0] exp_lba;
        int          delay;
        arg   = rand_bits(32);
        delay = long_wait ? 5000 + rand_bits(10) : rand_bits(6);
        sdhc  = mode;
        // SDSC hosts address in bytes
        exp_lba  = mode ? arg : (arg >> 9);
        ack_done = 1'b0;
        fork
            host_serve(exp_lba, delay);
            read_block(arg);
        join
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] c;
        logic [31:0] arg;
        int          k;
        clk_sys         = 1'b0;
        card_is_reset   = 1'b1;
        sd_cs           = 1'b1;
        sd_sck          = 1'b0;
        sd_sdi          = 1'b1;
        sdhc            = 1'b1;
        sd_ack          = 1'b0;
        host_wr         = '0;
        lfsr_state      = 32'h270f_cd56;
        ack_done        = 1'b0;
        model_idle_seen = 1'b0;
        model_cmd55     = 1'b0;
        errors          = 0;
        test_errors     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (2) @(negedge clk_sys);
        card_is_reset = 1'b0;
        @(negedge clk_sys);

        // idle lines after reset, cs still high
        if (sd_sdo != 1'b1) begin
            report_value("sd_sdo", 32'(sd_sdo), 32'h1);
        end
        if (host_req.rd != 1'b0) begin
            report_value("host_req.rd", 32'(host_req.rd), 32'h0);
        end
        sd_cs = 1'b0;
        @(negedge clk_sys);
        run_cmd(6'd1, 32'h0);
        run_cmd(6'd0, 32'h0);
        pulse_reset();
        run_cmd(6'd1, 32'h0);
        end_test(1, "reset and CMD0");

        run_cmd(6'd0, 32'h0);
        for (k = 0; k < 3; k++) begin
            v = rand_bits(4);
            c = rand_bits(8);
            run_cmd(6'd8, {20'h0, v[3:0], c[7:0]});
        end
        end_test(2, "CMD8 echo");

        sdhc = 1'b1;
        run_cmd(6'd58, 32'h0);
        sdhc = 1'b0;
        run_cmd(6'd58, 32'h0);
        sdhc = 1'b1;
        end_test(3, "CMD58 OCR");

        run_cmd(6'd16, 32'd512);
        arg = rand_bits(32);
        if (arg == 32'd512) begin
            arg = 32'd1024;
        end
        run_cmd(6'd16, arg);
        // ACMD41 needs a CMD55 right before it
        run_cmd(6'd41, 32'h4000_0000);
        run_cmd(6'd55, 32'h0);
        run_cmd(6'd41, 32'h4000_0000);
        end_test(4, "CMD16 and ACMD41");

        read_test(1'b1, 1'b0);
        read_test(1'b1, 1'b1);
        read_test(1'b0, 1'b0);
        read_test(1'b0, 1'b1);
        end_test(5, "CMD17 sector read");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
sd_proto_pkg.sv
sd_host_pkg.sv
sd_spi_rx.sv
sd_cmd_engine.sv
sd_spi_tx.sv
sd_sector_buffer.sv
sd_card_top.sv
tb_sd_card.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_sd_card
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
BIN       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
